// ==== hdl/mem_macros.svh ====
// ======================================
// memory map constants for the sram side
// include wherever the window or depth is needed
// ======================================

`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// first byte of the sram window
`define MEM_BASE_ADDR 32'h8000_0000

// log2 of the word count, 256 words of 32 bits
`define MEM_DEPTH_LOG2 8

// reset value of the slave address buffers
`define MEM_PC_RST `MEM_BASE_ADDR

`endif

// ==== hdl/mem_pkg.sv ====
// ======================================
// shared types for the memory subsystem
// modules pull this in by wildcard import
// ======================================

`include "mem_macros.svh"

package mem_pkg;

    // bus vectors
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;

    // axi response codes in use
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // word index into the array
    typedef logic [`MEM_DEPTH_LOG2-1:0] widx_t;

    // shared by the read and write fsm of the slave
    typedef enum logic [1:0] {
        XFER_IDLE,
        XFER_BUSY,
        XFER_DONE
    } xfer_state_t;

    // read grant owner
    typedef enum logic {
        OWNER_IFU,
        OWNER_LSU
    } rd_owner_t;

endpackage

// ==== hdl/sram_array.sv ====
// ======================================
// byte-enabled word array behind the slave
// one read port, one write port, same clock
// ======================================

`timescale 1ns/1ps

`include "mem_macros.svh"

module sram_array
    import mem_pkg::*;
(
    input  logic  clk,
    // read port
    input  logic  rd_en,
    input  widx_t rd_idx,
    output word_t rd_data,
    // write port
    input  logic  wr_en,
    input  widx_t wr_idx,
    input  word_t wr_data,
    input  strb_t wr_strb
);

    localparam int DEPTH = 1 << `MEM_DEPTH_LOG2;

    word_t mem [DEPTH];

    // registered read, output holds while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_idx];
        end
    end

    // one strobe bit per byte lane
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (wr_strb[lane]) begin
                    mem[wr_idx][lane*8 +: 8] <= wr_data[lane*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== hdl/axi_lite_sram.sv ====
// ======================================
// axi-lite slave in front of the sram array
// separate read and write fsm, one transfer each
// out of window accesses answer decerr
// ======================================

`timescale 1ns/1ps

`include "mem_macros.svh"

module axi_lite_sram
    import mem_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    // read address
    input  addr_t araddr,
    input  logic  arvalid,
    output logic  arready,
    // read data
    output word_t rdata,
    output resp_t rresp,
    output logic  rvalid,
    input  logic  rready,
    // write address
    input  addr_t awaddr,
    input  logic  awvalid,
    output logic  awready,
    // write data
    input  word_t wdata,
    input  strb_t wstrb,
    input  logic  wvalid,
    output logic  wready,
    // write response
    output resp_t bresp,
    output logic  bvalid,
    input  logic  bready,
    // array side
    output logic  mem_rd_en,
    output widx_t mem_rd_idx,
    input  word_t mem_rd_data,
    output logic  mem_wr_en,
    output widx_t mem_wr_idx,
    output word_t mem_wr_data,
    output strb_t mem_wr_strb
);

    xfer_state_t rd_state_q, rd_state_d;
    xfer_state_t wr_state_q, wr_state_d;

    addr_t araddr_q;
    addr_t awaddr_q;
    addr_t rd_off;
    addr_t wr_off;
    logic  rd_in_range;
    logic  wr_in_range;
    // range result latched alongside the state
    logic  rd_ok_q;
    logic  wr_ok_q;

    logic  ar_hs, r_hs, aw_hs, w_hs, b_hs;

    assign ar_hs = arvalid & arready;
    assign r_hs  = rvalid & rready;
    assign aw_hs = awvalid & awready;
    assign w_hs  = wvalid & wready;
    assign b_hs  = bvalid & bready;

    // ======================================
    // window decode
    // ======================================
    // below the base wraps high, so upper offset bits catch both sides
    assign rd_off      = araddr_q - `MEM_BASE_ADDR;
    assign wr_off      = awaddr_q - `MEM_BASE_ADDR;
    assign rd_in_range = (rd_off[31:`MEM_DEPTH_LOG2+2] == '0);
    assign wr_in_range = (wr_off[31:`MEM_DEPTH_LOG2+2] == '0);

    // ======================================
    // read channel
    // ======================================
    always_comb begin
        rd_state_d = rd_state_q;
        case (rd_state_q)
            XFER_IDLE: if (ar_hs) rd_state_d = XFER_BUSY;
            // array answers in one cycle
            XFER_BUSY: rd_state_d = XFER_DONE;
            XFER_DONE: if (r_hs) rd_state_d = XFER_IDLE;
            default:   rd_state_d = XFER_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state_q <= XFER_IDLE;
            araddr_q   <= `MEM_PC_RST;
            rd_ok_q    <= 1'b0;
        end else begin
            rd_state_q <= rd_state_d;
            if (ar_hs) begin
                araddr_q <= araddr;
            end
            if (rd_state_q == XFER_BUSY) begin
                rd_ok_q <= rd_in_range;
            end
        end
    end

    assign arready    = (rd_state_q == XFER_IDLE);
    assign rvalid     = (rd_state_q == XFER_DONE);
    // array output holds during done, so rdata is stable under back-pressure
    assign mem_rd_en  = (rd_state_q == XFER_BUSY);
    assign mem_rd_idx = rd_off[`MEM_DEPTH_LOG2+1:2];
    assign rdata      = rd_ok_q ? mem_rd_data : '0;
    assign rresp      = rd_ok_q ? RESP_OKAY : RESP_DECERR;

    // ======================================
    // write channel
    // ======================================
    always_comb begin
        wr_state_d = wr_state_q;
        case (wr_state_q)
            XFER_IDLE: if (aw_hs) wr_state_d = XFER_BUSY;
            XFER_BUSY: if (w_hs) wr_state_d = XFER_DONE;
            XFER_DONE: if (b_hs) wr_state_d = XFER_IDLE;
            default:   wr_state_d = XFER_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state_q <= XFER_IDLE;
            awaddr_q   <= `MEM_PC_RST;
            wr_ok_q    <= 1'b0;
        end else begin
            wr_state_q <= wr_state_d;
            if (aw_hs) begin
                awaddr_q <= awaddr;
            end
            if (w_hs) begin
                wr_ok_q <= wr_in_range;
            end
        end
    end

    assign awready     = (wr_state_q == XFER_IDLE);
    assign wready      = (wr_state_q == XFER_BUSY);
    assign bvalid      = (wr_state_q == XFER_DONE);
    assign bresp       = wr_ok_q ? RESP_OKAY : RESP_DECERR;
    // array write lands on the w handshake edge, dropped outside the window
    assign mem_wr_en   = w_hs & wr_in_range;
    assign mem_wr_idx  = wr_off[`MEM_DEPTH_LOG2+1:2];
    assign mem_wr_data = wdata;
    assign mem_wr_strb = wstrb;

endmodule

// ==== hdl/axi_lite_read_arbiter.sv ====
// ======================================
// two-master read arbiter for the sram slave
// combinational path, grant held until r handshake
// ======================================

`timescale 1ns/1ps

module axi_lite_read_arbiter
    import mem_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    // instruction fetch master
    input  addr_t ifu_araddr,
    input  logic  ifu_arvalid,
    output logic  ifu_arready,
    output word_t ifu_rdata,
    output resp_t ifu_rresp,
    output logic  ifu_rvalid,
    input  logic  ifu_rready,
    // load/store master
    input  addr_t lsu_araddr,
    input  logic  lsu_arvalid,
    output logic  lsu_arready,
    output word_t lsu_rdata,
    output resp_t lsu_rresp,
    output logic  lsu_rvalid,
    input  logic  lsu_rready,
    // slave side
    output addr_t s_araddr,
    output logic  s_arvalid,
    input  logic  s_arready,
    input  word_t s_rdata,
    input  resp_t s_rresp,
    input  logic  s_rvalid,
    output logic  s_rready
);

    rd_owner_t grant_q;
    rd_owner_t last_q;
    rd_owner_t pri;
    rd_owner_t sel;
    logic      lock_q;
    logic      pri_req;
    logic      any_req;
    logic      ifu_sel, lsu_sel;
    logic      ifu_owns, lsu_owns;

    // ======================================
    // grant select
    // ======================================
    // priority goes to whoever was not served last
    assign pri     = (last_q == OWNER_IFU) ? OWNER_LSU : OWNER_IFU;
    assign pri_req = (pri == OWNER_IFU) ? ifu_arvalid : lsu_arvalid;
    assign any_req = ifu_arvalid | lsu_arvalid;

    always_comb begin
        if (lock_q) begin
            sel = grant_q;
        end else if (pri_req || !any_req) begin
            sel = pri;
        end else begin
            // only the last served one is asking
            sel = last_q;
        end
    end

    assign ifu_sel = ~lock_q & (sel == OWNER_IFU);
    assign lsu_sel = ~lock_q & (sel == OWNER_LSU);

    // ar path, nothing goes out while a read is in flight
    assign s_araddr    = (sel == OWNER_IFU) ? ifu_araddr : lsu_araddr;
    assign s_arvalid   = ifu_sel ? ifu_arvalid : (lsu_sel & lsu_arvalid);
    assign ifu_arready = ifu_sel & s_arready;
    assign lsu_arready = lsu_sel & s_arready;

    // ======================================
    // r routing
    // ======================================
    assign ifu_owns = lock_q & (grant_q == OWNER_IFU);
    assign lsu_owns = lock_q & (grant_q == OWNER_LSU);

    assign ifu_rvalid = ifu_owns & s_rvalid;
    assign lsu_rvalid = lsu_owns & s_rvalid;
    assign ifu_rdata  = ifu_owns ? s_rdata : '0;
    assign lsu_rdata  = lsu_owns ? s_rdata : '0;
    assign ifu_rresp  = ifu_owns ? s_rresp : RESP_OKAY;
    assign lsu_rresp  = lsu_owns ? s_rresp : RESP_OKAY;
    assign s_rready   = (ifu_owns & ifu_rready) | (lsu_owns & lsu_rready);

    // lock at ar handshake, release at r handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            lock_q  <= 1'b0;
            grant_q <= OWNER_IFU;
            // ifu gets the first turn
            last_q  <= OWNER_LSU;
        end else if (s_arvalid && s_arready) begin
            lock_q  <= 1'b1;
            grant_q <= sel;
            last_q  <= sel;
        end else if (s_rvalid && s_rready) begin
            lock_q  <= 1'b0;
        end
    end

endmodule

// ==== hdl/mem_subsys_top.sv ====
// ======================================
// memory subsystem top, ifu and lsu masters
// read arbiter, axi-lite slave and sram array
// ======================================

`timescale 1ns/1ps

module mem_subsys_top
    import mem_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    // ifu read port
    input  addr_t ifu_araddr,
    input  logic  ifu_arvalid,
    output logic  ifu_arready,
    output word_t ifu_rdata,
    output resp_t ifu_rresp,
    output logic  ifu_rvalid,
    input  logic  ifu_rready,
    // lsu read port
    input  addr_t lsu_araddr,
    input  logic  lsu_arvalid,
    output logic  lsu_arready,
    output word_t lsu_rdata,
    output resp_t lsu_rresp,
    output logic  lsu_rvalid,
    input  logic  lsu_rready,
    // lsu write port
    input  addr_t lsu_awaddr,
    input  logic  lsu_awvalid,
    output logic  lsu_awready,
    input  word_t lsu_wdata,
    input  strb_t lsu_wstrb,
    input  logic  lsu_wvalid,
    output logic  lsu_wready,
    output resp_t lsu_bresp,
    output logic  lsu_bvalid,
    input  logic  lsu_bready
);

    // arbiter to slave read channel
    addr_t s_araddr;
    logic  s_arvalid;
    logic  s_arready;
    word_t s_rdata;
    resp_t s_rresp;
    logic  s_rvalid;
    logic  s_rready;

    // slave to array
    logic  mem_rd_en;
    widx_t mem_rd_idx;
    word_t mem_rd_data;
    logic  mem_wr_en;
    widx_t mem_wr_idx;
    word_t mem_wr_data;
    strb_t mem_wr_strb;

    axi_lite_read_arbiter arb_i (
        .clk         (clk),
        .rst         (rst),
        .ifu_araddr  (ifu_araddr),
        .ifu_arvalid (ifu_arvalid),
        .ifu_arready (ifu_arready),
        .ifu_rdata   (ifu_rdata),
        .ifu_rresp   (ifu_rresp),
        .ifu_rvalid  (ifu_rvalid),
        .ifu_rready  (ifu_rready),
        .lsu_araddr  (lsu_araddr),
        .lsu_arvalid (lsu_arvalid),
        .lsu_arready (lsu_arready),
        .lsu_rdata   (lsu_rdata),
        .lsu_rresp   (lsu_rresp),
        .lsu_rvalid  (lsu_rvalid),
        .lsu_rready  (lsu_rready),
        .s_araddr    (s_araddr),
        .s_arvalid   (s_arvalid),
        .s_arready   (s_arready),
        .s_rdata     (s_rdata),
        .s_rresp     (s_rresp),
        .s_rvalid    (s_rvalid),
        .s_rready    (s_rready)
    );

    // lsu writes go straight to the slave
    axi_lite_sram sram_ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .araddr      (s_araddr),
        .arvalid     (s_arvalid),
        .arready     (s_arready),
        .rdata       (s_rdata),
        .rresp       (s_rresp),
        .rvalid      (s_rvalid),
        .rready      (s_rready),
        .awaddr      (lsu_awaddr),
        .awvalid     (lsu_awvalid),
        .awready     (lsu_awready),
        .wdata       (lsu_wdata),
        .wstrb       (lsu_wstrb),
        .wvalid      (lsu_wvalid),
        .wready      (lsu_wready),
        .bresp       (lsu_bresp),
        .bvalid      (lsu_bvalid),
        .bready      (lsu_bready),
        .mem_rd_en   (mem_rd_en),
        .mem_rd_idx  (mem_rd_idx),
        .mem_rd_data (mem_rd_data),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_idx  (mem_wr_idx),
        .mem_wr_data (mem_wr_data),
        .mem_wr_strb (mem_wr_strb)
    );

    sram_array array_i (
        .clk     (clk),
        .rd_en   (mem_rd_en),
        .rd_idx  (mem_rd_idx),
        .rd_data (mem_rd_data),
        .wr_en   (mem_wr_en),
        .wr_idx  (mem_wr_idx),
        .wr_data (mem_wr_data),
        .wr_strb (mem_wr_strb)
    );

endmodule

// ==== bench/mem_checker.sv ====
// ======================================
// response checker for the memory subsystem
// testbench queues expectations, compared on r and b handshakes
// ======================================

`timescale 1ns/1ps

module mem_checker
    import mem_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input word_t ifu_rdata,
    input resp_t ifu_rresp,
    input logic  ifu_rvalid,
    input logic  ifu_rready,
    input word_t lsu_rdata,
    input resp_t lsu_rresp,
    input logic  lsu_rvalid,
    input logic  lsu_rready,
    input resp_t lsu_bresp,
    input logic  lsu_bvalid,
    input logic  lsu_bready
);

    // one queue set per response channel
    string ifu_name_q[$];
    word_t ifu_data_q[$];
    resp_t ifu_resp_q[$];
    string lsu_name_q[$];
    word_t lsu_data_q[$];
    resp_t lsu_resp_q[$];
    string wr_name_q[$];
    resp_t wr_resp_q[$];

    int pass_cnt = 0;
    int fail_cnt = 0;

    task automatic expect_read(input bit on_ifu, input string name,
                               input word_t data, input resp_t resp);
        if (on_ifu) begin
            ifu_name_q.push_back(name);
            ifu_data_q.push_back(data);
            ifu_resp_q.push_back(resp);
        end else begin
            lsu_name_q.push_back(name);
            lsu_data_q.push_back(data);
            lsu_resp_q.push_back(resp);
        end
    endtask

    task automatic expect_write(input string name, input resp_t resp);
        wr_name_q.push_back(name);
        wr_resp_q.push_back(resp);
    endtask

    function automatic int pending();
        pending = ifu_name_q.size() + lsu_name_q.size() + wr_name_q.size();
    endfunction

    task automatic report_read(input string name, input word_t exp_d, input resp_t exp_r,
                               input word_t got_d, input resp_t got_r);
        if (exp_d === got_d && exp_r === got_r) begin
            pass_cnt++;
            $display("passed %s  data %h resp %0d", name, got_d, got_r);
        end else begin
            fail_cnt++;
            $display("CHECK FAILED %s: expected data %h resp %0d, actual data %h resp %0d",
                     name, exp_d, exp_r, got_d, got_r);
        end
    endtask

    // sampled on the handshake edge, payload is stable there
    always @(posedge clk) begin
        if (!rst) begin
            if (ifu_rvalid && ifu_rready) begin
                if (ifu_name_q.size() == 0) begin
                    $display("ifu read response arrived with nothing expected");
                    fail_cnt++;
                end else begin
                    report_read(ifu_name_q.pop_front(), ifu_data_q.pop_front(),
                                ifu_resp_q.pop_front(), ifu_rdata, ifu_rresp);
                end
            end
            if (lsu_rvalid && lsu_rready) begin
                if (lsu_name_q.size() == 0) begin
                    $display("lsu read response arrived with nothing expected");
                    fail_cnt++;
                end else begin
                    report_read(lsu_name_q.pop_front(), lsu_data_q.pop_front(),
                                lsu_resp_q.pop_front(), lsu_rdata, lsu_rresp);
                end
            end
            if (lsu_bvalid && lsu_bready) begin
                if (wr_name_q.size() == 0) begin
                    $display("write response arrived with nothing expected");
                    fail_cnt++;
                end else if (wr_resp_q[0] === lsu_bresp) begin
                    pass_cnt++;
                    $display("passed %s  bresp %0d", wr_name_q.pop_front(), lsu_bresp);
                    void'(wr_resp_q.pop_front());
                end else begin
                    fail_cnt++;
                    $display("CHECK FAILED %s: expected bresp %0d, actual bresp %0d",
                             wr_name_q.pop_front(), wr_resp_q.pop_front(), lsu_bresp);
                end
            end
        end
    end

endmodule

// ==== bench/mem_assertions.sv ====
// ======================================
// handshake properties bound into mem_subsys_top
// ======================================

`timescale 1ns/1ps

module mem_assertions
    import mem_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input word_t ifu_rdata,
    input resp_t ifu_rresp,
    input logic  ifu_rvalid,
    input logic  ifu_rready,
    input word_t lsu_rdata,
    input resp_t lsu_rresp,
    input logic  lsu_rvalid,
    input logic  lsu_rready,
    input logic  lsu_wvalid,
    input logic  lsu_wready,
    input resp_t lsu_bresp,
    input logic  lsu_bvalid,
    input logic  lsu_bready,
    input logic  s_arvalid,
    input logic  s_rvalid
);

    int fail_cnt = 0;

    // responses hold under back-pressure
    ifu_r_stable: assert property (@(posedge clk) disable iff (rst)
        ifu_rvalid && !ifu_rready |=> ifu_rvalid && $stable(ifu_rdata) && $stable(ifu_rresp))
    else begin
        fail_cnt++;
        $error("ifu read response changed while stalled");
    end
    lsu_r_stable: assert property (@(posedge clk) disable iff (rst)
        lsu_rvalid && !lsu_rready |=> lsu_rvalid && $stable(lsu_rdata) && $stable(lsu_rresp))
    else begin
        fail_cnt++;
        $error("lsu read response changed while stalled");
    end
    b_stable: assert property (@(posedge clk) disable iff (rst)
        lsu_bvalid && !lsu_bready |=> lsu_bvalid && $stable(lsu_bresp))
    else begin
        fail_cnt++;
        $error("write response changed while stalled");
    end

    // r goes to one master at a time
    r_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(ifu_rvalid && lsu_rvalid))
    else begin
        fail_cnt++;
        $error("ifu and lsu rvalid high together");
    end

    // b only follows an accepted w beat
    b_after_w: assert property (@(posedge clk) disable iff (rst)
        $rose(lsu_bvalid) |-> $past(lsu_wvalid && lsu_wready))
    else begin
        fail_cnt++;
        $error("bvalid rose without a w handshake");
    end

    // arbiter keeps the slave ar quiet until the pending read is taken
    no_ar_in_flight: assert property (@(posedge clk) disable iff (rst)
        s_rvalid |-> !s_arvalid)
    else begin
        fail_cnt++;
        $error("slave was offered an ar with rvalid pending");
    end

endmodule

bind mem_subsys_top mem_assertions assert_i (
    .clk        (clk),
    .rst        (rst),
    .ifu_rdata  (ifu_rdata),
    .ifu_rresp  (ifu_rresp),
    .ifu_rvalid (ifu_rvalid),
    .ifu_rready (ifu_rready),
    .lsu_rdata  (lsu_rdata),
    .lsu_rresp  (lsu_rresp),
    .lsu_rvalid (lsu_rvalid),
    .lsu_rready (lsu_rready),
    .lsu_wvalid (lsu_wvalid),
    .lsu_wready (lsu_wready),
    .lsu_bresp  (lsu_bresp),
    .lsu_bvalid (lsu_bvalid),
    .lsu_bready (lsu_bready),
    .s_arvalid  (s_arvalid),
    .s_rvalid   (s_rvalid)
);

// ==== bench/tb_mem_subsys.sv ====
// ======================================
// testbench for the memory subsystem top
// replays bench/mem_trace.txt on the ifu and lsu ports
// mem_checker compares, this module prints the result
// ======================================

`timescale 1ns/1ps

module tb_mem_subsys
    import mem_pkg::*;
;

    localparam int MAX_LINES = 64;

    logic  clk = 1'b0;
    logic  rst;
    addr_t ifu_araddr;
    logic  ifu_arvalid, ifu_arready;
    word_t ifu_rdata;
    resp_t ifu_rresp;
    logic  ifu_rvalid, ifu_rready;
    addr_t lsu_araddr;
    logic  lsu_arvalid, lsu_arready;
    word_t lsu_rdata;
    resp_t lsu_rresp;
    logic  lsu_rvalid, lsu_rready;
    addr_t lsu_awaddr;
    logic  lsu_awvalid, lsu_awready;
    word_t lsu_wdata;
    strb_t lsu_wstrb;
    logic  lsu_wvalid, lsu_wready;
    resp_t lsu_bresp;
    logic  lsu_bvalid, lsu_bready;

    // trace contents, one entry per data line
    string t_name [MAX_LINES];
    string t_op   [MAX_LINES];
    string t_port [MAX_LINES];
    addr_t t_addr [MAX_LINES];
    word_t t_data [MAX_LINES];
    strb_t t_strb [MAX_LINES];
    resp_t t_resp [MAX_LINES];
    addr_t t_addr2[MAX_LINES];
    word_t t_data2[MAX_LINES];
    int    t_bp   [MAX_LINES];
    int    n_lines = 0;

    integer seed = 32'hf473;
    int     cycle_cnt = 0;
    int     cycle_limit = 0;
    int     other_errs = 0;
    int     assert_errs;
    bit     load_ok;

    // 100 ns period
    always #50 clk = ~clk;

    mem_subsys_top dut_i (.*);

    mem_checker chk_i (
        .clk        (clk),
        .rst        (rst),
        .ifu_rdata  (ifu_rdata),
        .ifu_rresp  (ifu_rresp),
        .ifu_rvalid (ifu_rvalid),
        .ifu_rready (ifu_rready),
        .lsu_rdata  (lsu_rdata),
        .lsu_rresp  (lsu_rresp),
        .lsu_rvalid (lsu_rvalid),
        .lsu_rready (lsu_rready),
        .lsu_bresp  (lsu_bresp),
        .lsu_bvalid (lsu_bvalid),
        .lsu_bready (lsu_bready)
    );

    // ======================================
    // timeout
    // ======================================
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("simulation timed out waiting for a response after %0d cycles",
                     cycle_cnt);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // back-pressure length, 0 to 3 cycles
    function automatic int pick_delay();
        pick_delay = $random(seed) & 3;
    endfunction

    function automatic bit ar_fire(input bit on_ifu);
        ar_fire = on_ifu ? (ifu_arvalid && ifu_arready) : (lsu_arvalid && lsu_arready);
    endfunction

    function automatic bit r_seen(input bit on_ifu);
        r_seen = on_ifu ? ifu_rvalid : lsu_rvalid;
    endfunction

    function automatic bit r_fire(input bit on_ifu);
        r_fire = on_ifu ? (ifu_rvalid && ifu_rready) : (lsu_rvalid && lsu_rready);
    endfunction

    task automatic load_trace(output bit ok);
        int fd;
        int n;
        string tok;
        logic [8*256-1:0] rest;
        ok = 1'b0;
        fd = $fopen("bench/mem_trace.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok[0] == "#") begin
                    // column notes, skip the rest of the line
                    n = $fgets(rest, fd);
                end else if (n_lines < MAX_LINES) begin
                    t_name[n_lines] = tok;
                    n = $fscanf(fd, "%s %s %h %h %h %h %h %h %d",
                                t_op[n_lines], t_port[n_lines], t_addr[n_lines],
                                t_data[n_lines], t_strb[n_lines], t_resp[n_lines],
                                t_addr2[n_lines], t_data2[n_lines], t_bp[n_lines]);
                    if (n != 9) begin
                        $display("trace line %s has missing fields", tok);
                        ok = 1'b0;
                    end
                    n_lines++;
                end else begin
                    $display("trace holds more than %0d lines", MAX_LINES);
                    ok = 1'b0;
                    n = $fgets(rest, fd);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic do_write(input string name, input addr_t a, input word_t d,
                            input strb_t s, input resp_t exp_resp, input int bp);
        int delay;
        delay = bp ? pick_delay() : 0;
        chk_i.expect_write(name, exp_resp);
        @(negedge clk);
        lsu_awaddr  = a;
        lsu_awvalid = 1'b1;
        lsu_wdata   = d;
        lsu_wstrb   = s;
        lsu_wvalid  = 1'b1;
        lsu_bready  = (delay == 0);
        do @(posedge clk); while (!(lsu_awvalid && lsu_awready));
        @(negedge clk);
        lsu_awvalid = 1'b0;
        // wready opens only after the aw handshake
        do @(posedge clk); while (!(lsu_wvalid && lsu_wready));
        @(negedge clk);
        lsu_wvalid = 1'b0;
        if (delay > 0) begin
            repeat (delay) @(negedge clk);
            lsu_bready = 1'b1;
        end
        do @(posedge clk); while (!(lsu_bvalid && lsu_bready));
    endtask

    task automatic do_read(input bit on_ifu, input string name, input addr_t a,
                           input word_t exp_data, input resp_t exp_resp, input int bp);
        int delay;
        delay = bp ? pick_delay() : 0;
        chk_i.expect_read(on_ifu, name, exp_data, exp_resp);
        @(negedge clk);
        if (on_ifu) begin
            ifu_araddr  = a;
            ifu_arvalid = 1'b1;
            ifu_rready  = (delay == 0);
        end else begin
            lsu_araddr  = a;
            lsu_arvalid = 1'b1;
            lsu_rready  = (delay == 0);
        end
        // may wait behind the other master
        do @(posedge clk); while (!ar_fire(on_ifu));
        @(negedge clk);
        if (on_ifu) ifu_arvalid = 1'b0;
        else lsu_arvalid = 1'b0;
        if (delay > 0) begin
            do @(posedge clk); while (!r_seen(on_ifu));
            repeat (delay) @(negedge clk);
            if (on_ifu) ifu_rready = 1'b1;
            else lsu_rready = 1'b1;
        end
        do @(posedge clk); while (!r_fire(on_ifu));
    endtask

    // ======================================
    // main sequence
    // ======================================
    initial begin
        rst = 1'b1;
        ifu_araddr = '0;
        ifu_arvalid = 1'b0;
        ifu_rready = 1'b1;
        lsu_araddr = '0;
        lsu_arvalid = 1'b0;
        lsu_rready = 1'b1;
        lsu_awaddr = '0;
        lsu_awvalid = 1'b0;
        lsu_wdata = '0;
        lsu_wstrb = '0;
        lsu_wvalid = 1'b0;
        lsu_bready = 1'b1;
        load_trace(load_ok);
        if (!load_ok) begin
            $display("could not read the trace file bench/mem_trace.txt");
            $display("TEST RESULT: FAIL");
        end else begin
            cycle_limit = n_lines * 20 + 16;
            repeat (16) @(negedge clk);
            rst = 1'b0;
            for (int i = 0; i < n_lines; i++) begin
                if (t_op[i] == "W") begin
                    do_write(t_name[i], t_addr[i], t_data[i], t_strb[i], t_resp[i], t_bp[i]);
                end else if (t_op[i] == "R") begin
                    do_read(t_port[i] == "ifu", t_name[i], t_addr[i], t_data[i],
                            t_resp[i], t_bp[i]);
                end else if (t_op[i] == "P") begin
                    // both masters raise arvalid on the same edge
                    fork
                        do_read(1'b1, {t_name[i], "_ifu"}, t_addr[i], t_data[i], t_resp[i], 0);
                        do_read(1'b0, {t_name[i], "_lsu"}, t_addr2[i], t_data2[i], t_resp[i], 0);
                    join
                end else begin
                    $display("unknown operation %s on trace line %s", t_op[i], t_name[i]);
                    other_errs++;
                end
            end
            repeat (4) @(negedge clk);
            if (chk_i.pending() != 0) begin
                $display("%0d expected responses never arrived", chk_i.pending());
                other_errs++;
            end
            assert_errs = dut_i.assert_i.fail_cnt;
            $display("%0d checks passed, %0d checks failed, %0d assertion errors, %0d other errors",
                     chk_i.pass_cnt, chk_i.fail_cnt, assert_errs, other_errs);
            if (chk_i.fail_cnt == 0 && assert_errs == 0 && other_errs == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
        end
        $finish;
    end

endmodule

// ==== bench/mem_trace.txt ====
# name op port addr data strb resp addr2 data2 bp (hex except bp)
# W writes on lsu, R reads on port, P reads ifu at addr and lsu at addr2; bp=1 stalls ready
full_wr    W lsu 80000000 deadbeef f 0 0 0 0
full_rd    R lsu 80000000 deadbeef 0 0 0 0 0
part_base  W lsu 80000004 11223344 f 0 0 0 0
part_wr    W lsu 80000004 aabbccdd 5 0 0 0 0
part_rd    R lsu 80000004 11bb33dd 0 0 0 0 0
ifu_rd     R ifu 80000000 deadbeef 0 0 0 0 0
ifu_part   R ifu 80000004 11bb33dd 0 0 0 0 0
keep_wr    W lsu 80000010 cafef00d f 0 0 0 0
oor_wr     W lsu 90000010 12345678 f 3 0 0 0
oor_rd     R lsu 90000010 00000000 0 3 0 0 0
oor_low    R ifu 7ffffff0 00000000 0 3 0 0 0
keep_rd    R lsu 80000010 cafef00d 0 0 0 0 0
top_wr     W lsu 800003fc 76543210 f 0 0 0 0
top_rd     R ifu 800003fc 76543210 0 0 0 0 0
past_wr    W lsu 80000400 55555555 f 3 0 0 0
past_rd    R lsu 80000000 deadbeef 0 0 0 0 0
pair_a_wr  W lsu 80000020 01020304 f 0 0 0 0
pair_b_wr  W lsu 80000024 a5a5a5a5 f 0 0 0 0
pair       P -   80000020 01020304 0 0 80000024 a5a5a5a5 0
bp_wr      W lsu 80000030 0badcafe f 0 0 0 1
bp_rd      R lsu 80000030 0badcafe 0 0 0 0 1
bp_ifu     R ifu 80000030 0badcafe 0 0 0 0 1
bp_oor     W lsu 90000030 00000000 f 3 0 0 1

// ==== filelist.f ====
+incdir+hdl
hdl/mem_pkg.sv
hdl/sram_array.sv
hdl/axi_lite_sram.sv
hdl/axi_lite_read_arbiter.sv
hdl/mem_subsys_top.sv
bench/mem_checker.sv
bench/mem_assertions.sv
bench/tb_mem_subsys.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mem_pkg.sv
      - hdl/sram_array.sv
      - hdl/axi_lite_sram.sv
      - hdl/axi_lite_read_arbiter.sv
      - hdl/mem_subsys_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/mem_checker.sv
      - bench/mem_assertions.sv
      - bench/tb_mem_subsys.sv
